//--- decode_pkg.sv
package decode_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and field types
   ////////////////////////////////////////////////////////////

   localparam int WORD_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int OPCODE_W   = 6;
   localparam int FUNCT_W    = 6;
   localparam int IMM_W      = 16;
   localparam int SHAMT_W    = 5;
   localparam int JUMP_IMM_W = 26;
   localparam int ALU_OP_W   = 4;
   localparam int DSIZE_W    = 2;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [OPCODE_W-1:0]   opcode_t;
   typedef logic [FUNCT_W-1:0]    funct_t;
   typedef logic [IMM_W-1:0]      imm_t;
   typedef logic [SHAMT_W-1:0]    shamt_t;
   typedef logic [JUMP_IMM_W-1:0] jump_imm_t;
   typedef logic [ALU_OP_W-1:0]   alu_op_t;
   typedef logic [DSIZE_W-1:0]    dsize_t;

   localparam int        NUM_REGS = 32;
   localparam reg_addr_t RA_REG   = 5'd31;

   // Bit positions inside the instruction word
   localparam int OPCODE_MSB   = 31;
   localparam int RS_MSB       = 25;
   localparam int RT_MSB       = 20;
   localparam int RD_MSB       = 15;
   localparam int SHAMT_MSB    = 10;
   localparam int FUNCT_MSB    = 5;
   localparam int IMM_MSB      = 15;
   localparam int JUMP_IMM_MSB = 25;

   localparam dsize_t DSIZE_BYTE = 2'd0;
   localparam dsize_t DSIZE_HALF = 2'd1;
   localparam dsize_t DSIZE_WORD = 2'd2;

   ////////////////////////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////////////////////////

   localparam opcode_t OP_RTYPE = 6'b000000;
   localparam opcode_t OP_LB    = 6'b100000;
   localparam opcode_t OP_LH    = 6'b100001;
   localparam opcode_t OP_LW    = 6'b100011;
   localparam opcode_t OP_LBU   = 6'b100100;
   localparam opcode_t OP_LHU   = 6'b100101;
   localparam opcode_t OP_LWU   = 6'b100111;
   localparam opcode_t OP_SB    = 6'b101000;
   localparam opcode_t OP_SH    = 6'b101001;
   localparam opcode_t OP_SW    = 6'b101011;
   localparam opcode_t OP_ADDI  = 6'b001001;
   localparam opcode_t OP_ANDI  = 6'b001100;
   localparam opcode_t OP_ORI   = 6'b001101;
   localparam opcode_t OP_XORI  = 6'b001110;
   localparam opcode_t OP_LUI   = 6'b001111;
   localparam opcode_t OP_SLTI  = 6'b001010;
   localparam opcode_t OP_BEQ   = 6'b000100;
   localparam opcode_t OP_BNE   = 6'b000101;
   localparam opcode_t OP_J     = 6'b000010;
   localparam opcode_t OP_JAL   = 6'b000011;

   // R-type function field
   localparam funct_t FN_SLL  = 6'b000000;
   localparam funct_t FN_SRL  = 6'b000010;
   localparam funct_t FN_SRA  = 6'b000011;
   localparam funct_t FN_SLLV = 6'b000100;
   localparam funct_t FN_SRLV = 6'b000110;
   localparam funct_t FN_SRAV = 6'b000111;
   localparam funct_t FN_ADDU = 6'b100001;
   localparam funct_t FN_SUBU = 6'b100011;
   localparam funct_t FN_AND  = 6'b100100;
   localparam funct_t FN_OR   = 6'b100101;
   localparam funct_t FN_XOR  = 6'b100110;
   localparam funct_t FN_NOR  = 6'b100111;
   localparam funct_t FN_SLT  = 6'b101010;
   localparam funct_t FN_JR   = 6'b001000;
   localparam funct_t FN_JALR = 6'b001001;

   // ALU operations seen by EX
   localparam alu_op_t ALU_ADD = 4'b0000;
   localparam alu_op_t ALU_SUB = 4'b0001;
   localparam alu_op_t ALU_AND = 4'b0010;
   localparam alu_op_t ALU_OR  = 4'b0011;
   localparam alu_op_t ALU_XOR = 4'b0100;
   localparam alu_op_t ALU_NOR = 4'b0101;
   localparam alu_op_t ALU_SRL = 4'b0110;
   localparam alu_op_t ALU_SLL = 4'b0111;
   localparam alu_op_t ALU_SRA = 4'b1000;
   localparam alu_op_t ALU_SLT = 4'b1010;
   localparam alu_op_t ALU_LUI = 4'b1011;

   ////////////////////////////////////////////////////////////
   // Control frames
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      alu_op_t alu_op;
      logic    use_imm;
      logic    imm_unsigned;
      logic    use_shamt;
   } ex_ctrl_t;

   typedef struct packed {
      logic   rd_en;
      logic   wr_en;
      logic   load_unsigned;
      dsize_t dsize;
   } mem_ctrl_t;

   typedef struct packed {
      reg_addr_t dest;
      logic      reg_we;
      logic      from_alu;
      logic      link_pc;
   } wb_ctrl_t;

   typedef struct packed {
      alu_op_t alu_op;
      logic    use_shamt;
      logic    link_pc;
      logic    jump_reg;
   } func_ctrl_t;

   typedef struct packed {
      ex_ctrl_t  ex;
      mem_ctrl_t mem;
      logic      reg_we;
      logic      from_alu;
      logic      link_pc;
      logic      to_ra;
      logic      is_branch;
      logic      branch_ne;
      logic      jump_imm;
      logic      jump_reg;
   } dec_ctrl_t;

endpackage

//--- id_regfile.sv
`timescale 1ns/10ps

module id_regfile (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_we,
   input  decode_pkg::reg_addr_t i_waddr,
   input  decode_pkg::word_t     i_wdata,
   input  decode_pkg::reg_addr_t i_raddr_a,
   input  decode_pkg::reg_addr_t i_raddr_b,
   output decode_pkg::word_t     o_rdata_a,
   output decode_pkg::word_t     o_rdata_b
);

   import decode_pkg::*;

   word_t regs [NUM_REGS];

   // Write port
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // Read ports, no bypass from the write port
   assign o_rdata_a = regs[i_raddr_a];
   assign o_rdata_b = regs[i_raddr_b];

endmodule

//--- id_func_decoder.sv
`timescale 1ns/10ps

module id_func_decoder (
   input  decode_pkg::funct_t     i_funct,
   output decode_pkg::func_ctrl_t o_func
);

   import decode_pkg::*;

   always_comb begin
      o_func = '0;
      case (i_funct)
         // Constant shift amount
         FN_SLL: begin
            o_func.alu_op    = ALU_SLL;
            o_func.use_shamt = 1'b1;
         end
         FN_SRL: begin
            o_func.alu_op    = ALU_SRL;
            o_func.use_shamt = 1'b1;
         end
         FN_SRA: begin
            o_func.alu_op    = ALU_SRA;
            o_func.use_shamt = 1'b1;
         end
         // Shift amount from rs
         FN_SLLV: o_func.alu_op = ALU_SLL;
         FN_SRLV: o_func.alu_op = ALU_SRL;
         FN_SRAV: o_func.alu_op = ALU_SRA;
         FN_ADDU: o_func.alu_op = ALU_ADD;
         FN_SUBU: o_func.alu_op = ALU_SUB;
         FN_AND:  o_func.alu_op = ALU_AND;
         FN_OR:   o_func.alu_op = ALU_OR;
         FN_XOR:  o_func.alu_op = ALU_XOR;
         FN_NOR:  o_func.alu_op = ALU_NOR;
         FN_SLT:  o_func.alu_op = ALU_SLT;
         FN_JR: begin
            o_func.jump_reg = 1'b1;
         end
         FN_JALR: begin
            o_func.jump_reg = 1'b1;
            o_func.link_pc  = 1'b1;
         end
         default: begin
            o_func = '0;
         end
      endcase
   end

endmodule

//--- id_main_decoder.sv
`timescale 1ns/10ps

module id_main_decoder (
   input  decode_pkg::opcode_t    i_opcode,
   input  decode_pkg::func_ctrl_t i_func,
   output decode_pkg::dec_ctrl_t  o_ctrl
);

   import decode_pkg::*;

   // Access size from the low opcode bits of loads and stores
   function automatic dsize_t mem_size(input opcode_t op);
      dsize_t size;
      case (op)
         OP_LB, OP_LBU, OP_SB: size = DSIZE_BYTE;
         OP_LH, OP_LHU, OP_SH: size = DSIZE_HALF;
         default:              size = DSIZE_WORD;
      endcase
      return size;
   endfunction

   always_comb begin
      o_ctrl = '0;
      case (i_opcode)
         ////////////////////////////////////////////////////////////
         // Register ALU ops, JR and JALR
         ////////////////////////////////////////////////////////////
         OP_RTYPE: begin
            o_ctrl.reg_we       = 1'b1;
            o_ctrl.from_alu     = 1'b1;
            o_ctrl.ex.alu_op    = i_func.alu_op;
            o_ctrl.ex.use_shamt = i_func.use_shamt;
            o_ctrl.link_pc      = i_func.link_pc;
            o_ctrl.jump_reg     = i_func.jump_reg;
         end

         ////////////////////////////////////////////////////////////
         // Memory access
         ////////////////////////////////////////////////////////////
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            o_ctrl.mem.rd_en         = 1'b1;
            o_ctrl.mem.dsize         = mem_size(i_opcode);
            o_ctrl.mem.load_unsigned = i_opcode inside {OP_LBU, OP_LHU, OP_LWU};
            o_ctrl.ex.use_imm        = 1'b1;
            o_ctrl.reg_we            = 1'b1;
         end
         OP_SB, OP_SH, OP_SW: begin
            o_ctrl.mem.wr_en  = 1'b1;
            o_ctrl.mem.dsize  = mem_size(i_opcode);
            o_ctrl.ex.use_imm = 1'b1;
         end

         ////////////////////////////////////////////////////////////
         // Immediate ALU ops
         ////////////////////////////////////////////////////////////
         OP_ADDI, OP_SLTI: begin
            o_ctrl.ex.alu_op  = (i_opcode == OP_ADDI) ? ALU_ADD : ALU_SLT;
            o_ctrl.ex.use_imm = 1'b1;
            o_ctrl.reg_we     = 1'b1;
            o_ctrl.from_alu   = 1'b1;
         end
         OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            case (i_opcode)
               OP_ANDI: o_ctrl.ex.alu_op = ALU_AND;
               OP_ORI:  o_ctrl.ex.alu_op = ALU_OR;
               OP_XORI: o_ctrl.ex.alu_op = ALU_XOR;
               default: o_ctrl.ex.alu_op = ALU_LUI;
            endcase
            // Zero extended immediate
            o_ctrl.ex.imm_unsigned = 1'b1;
            o_ctrl.ex.use_imm      = 1'b1;
            o_ctrl.reg_we          = 1'b1;
            o_ctrl.from_alu        = 1'b1;
         end

         // Branches and jumps
         OP_BEQ, OP_BNE: begin
            o_ctrl.is_branch  = 1'b1;
            o_ctrl.branch_ne  = (i_opcode == OP_BNE);
            o_ctrl.ex.use_imm = 1'b1;
         end
         OP_J: begin
            o_ctrl.jump_imm = 1'b1;
         end
         OP_JAL: begin
            o_ctrl.jump_imm = 1'b1;
            o_ctrl.to_ra    = 1'b1;
            o_ctrl.reg_we   = 1'b1;
            o_ctrl.link_pc  = 1'b1;
         end

         default: begin
            o_ctrl = '0;
         end
      endcase
   end

endmodule

//--- id_branch_unit.sv
`timescale 1ns/10ps

module id_branch_unit (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  decode_pkg::word_t     i_rs_data,
   input  decode_pkg::word_t     i_rt_data,
   input  decode_pkg::dec_ctrl_t i_ctrl,
   input  decode_pkg::jump_imm_t i_jump_imm,
   output logic                  o_branch,
   output logic                  o_jump_rs,
   output logic                  o_jump_inm,
   output logic                  o_nop,
   output decode_pkg::jump_imm_t o_jump_imm_addr
);

   logic equal;
   logic taken;

   // Compare on the operands read this cycle
   assign equal = (i_rs_data == i_rt_data);
   assign taken = i_ctrl.is_branch & (i_ctrl.branch_ne ? ~equal : equal);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_branch        <= 1'b0;
         o_jump_rs       <= 1'b0;
         o_jump_inm      <= 1'b0;
         o_nop           <= 1'b0;
         o_jump_imm_addr <= '0;
      end else begin
         o_branch        <= i_ctrl.is_branch;
         o_jump_rs       <= i_ctrl.jump_reg;
         o_jump_inm      <= i_ctrl.jump_imm;
         // Squash the slot fetched behind a change of flow
         o_nop           <= taken | i_ctrl.jump_imm | i_ctrl.jump_reg;
         o_jump_imm_addr <= i_jump_imm;
      end
   end

endmodule

//--- id_stage_regs.sv
`timescale 1ns/10ps

module id_stage_regs (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  decode_pkg::dec_ctrl_t i_ctrl,
   input  decode_pkg::reg_addr_t i_rt,
   input  decode_pkg::reg_addr_t i_rd,
   input  decode_pkg::imm_t      i_imm,
   input  decode_pkg::shamt_t    i_shamt,
   input  decode_pkg::word_t     i_pc,
   output decode_pkg::ex_ctrl_t  o_ex_ctrl,
   output decode_pkg::mem_ctrl_t o_mem_ctrl,
   output decode_pkg::wb_ctrl_t  o_wb_ctrl,
   output decode_pkg::imm_t      o_imm,
   output decode_pkg::shamt_t    o_shamt,
   output decode_pkg::word_t     o_pc
);

   import decode_pkg::*;

   reg_addr_t dest;
   wb_ctrl_t  wb_next;

   // Link goes to r31, I-format writes rt, R-format writes rd
   always_comb begin
      if (i_ctrl.to_ra) begin
         dest = RA_REG;
      end else if (i_ctrl.ex.use_imm) begin
         dest = i_rt;
      end else begin
         dest = i_rd;
      end
   end

   assign wb_next = '{
      dest:     dest,
      reg_we:   i_ctrl.reg_we,
      from_alu: i_ctrl.from_alu,
      link_pc:  i_ctrl.link_pc
   };

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_ctrl  <= '0;
         o_mem_ctrl <= '0;
         o_wb_ctrl  <= '0;
         o_pc       <= '0;
      end else begin
         o_ex_ctrl  <= i_ctrl.ex;
         o_mem_ctrl <= i_ctrl.mem;
         o_wb_ctrl  <= wb_next;
         o_pc       <= i_pc;
      end
   end

   // Operand fields
   always_ff @(posedge i_clk) begin
      o_imm   <= i_imm;
      o_shamt <= i_shamt;
   end

endmodule

//--- instruction_decode.sv
`timescale 1ns/10ps

module instruction_decode (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  decode_pkg::word_t     i_instruction,
   input  decode_pkg::word_t     i_pc,
   input  logic                  i_regfile_we,
   input  decode_pkg::reg_addr_t i_regfile_addr,
   input  decode_pkg::word_t     i_regfile_data,
   output decode_pkg::word_t     o_a,
   output decode_pkg::word_t     o_b,
   output decode_pkg::ex_ctrl_t  o_ex_ctrl,
   output decode_pkg::mem_ctrl_t o_mem_ctrl,
   output decode_pkg::wb_ctrl_t  o_wb_ctrl,
   output decode_pkg::imm_t      o_imm,
   output decode_pkg::shamt_t    o_shamt,
   output decode_pkg::word_t     o_pc,
   output logic                  o_branch,
   output logic                  o_jump_rs,
   output logic                  o_jump_inm,
   output decode_pkg::jump_imm_t o_jump_imm_addr,
   output logic                  o_nop
);

   import decode_pkg::*;

   opcode_t    opcode;
   funct_t     funct;
   reg_addr_t  rs;
   reg_addr_t  rt;
   reg_addr_t  rd;
   imm_t       imm;
   shamt_t     shamt;
   jump_imm_t  jump_imm;

   func_ctrl_t func_ctrl;
   dec_ctrl_t  dec_ctrl;

   ////////////////////////////////////////////////////////////
   // Instruction fields
   ////////////////////////////////////////////////////////////

   assign opcode   = i_instruction[OPCODE_MSB -: OPCODE_W];
   assign rs       = i_instruction[RS_MSB -: REG_ADDR_W];
   assign rt       = i_instruction[RT_MSB -: REG_ADDR_W];
   assign rd       = i_instruction[RD_MSB -: REG_ADDR_W];
   assign shamt    = i_instruction[SHAMT_MSB -: SHAMT_W];
   assign funct    = i_instruction[FUNCT_MSB -: FUNCT_W];
   assign imm      = i_instruction[IMM_MSB -: IMM_W];
   assign jump_imm = i_instruction[JUMP_IMM_MSB -: JUMP_IMM_W];

   ////////////////////////////////////////////////////////////
   // Datapath and control
   ////////////////////////////////////////////////////////////

   id_regfile u_regfile (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_we      (i_regfile_we),
      .i_waddr   (i_regfile_addr),
      .i_wdata   (i_regfile_data),
      .i_raddr_a (rs),
      .i_raddr_b (rt),
      .o_rdata_a (o_a),
      .o_rdata_b (o_b)
   );

   id_func_decoder u_func_decoder (
      .i_funct (funct),
      .o_func  (func_ctrl)
   );

   id_main_decoder u_main_decoder (
      .i_opcode (opcode),
      .i_func   (func_ctrl),
      .o_ctrl   (dec_ctrl)
   );

   id_branch_unit u_branch_unit (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_rs_data       (o_a),
      .i_rt_data       (o_b),
      .i_ctrl          (dec_ctrl),
      .i_jump_imm      (jump_imm),
      .o_branch        (o_branch),
      .o_jump_rs       (o_jump_rs),
      .o_jump_inm      (o_jump_inm),
      .o_nop           (o_nop),
      .o_jump_imm_addr (o_jump_imm_addr)
   );

   id_stage_regs u_stage_regs (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ctrl     (dec_ctrl),
      .i_rt       (rt),
      .i_rd       (rd),
      .i_imm      (imm),
      .i_shamt    (shamt),
      .i_pc       (i_pc),
      .o_ex_ctrl  (o_ex_ctrl),
      .o_mem_ctrl (o_mem_ctrl),
      .o_wb_ctrl  (o_wb_ctrl),
      .o_imm      (o_imm),
      .o_shamt    (o_shamt),
      .o_pc       (o_pc)
   );

endmodule

//--- tb_instruction_decode_assert.sv
`timescale 1ns/10ps

module tb_instruction_decode_assert (
   input logic                  i_clk,
   input logic                  i_rst,
   input decode_pkg::ex_ctrl_t  i_ex_ctrl,
   input decode_pkg::mem_ctrl_t i_mem_ctrl,
   input decode_pkg::wb_ctrl_t  i_wb_ctrl,
   input decode_pkg::word_t     i_pc,
   input logic                  i_branch,
   input logic                  i_jump_rs,
   input logic                  i_jump_inm,
   input logic                  i_nop
);

   // Failed assertions, read back by the end of the run
   int fail_count = 0;

   // Squash only follows a change of flow
   nop_has_cause: assert property (@(posedge i_clk) disable iff (i_rst)
      i_nop |-> (i_branch || i_jump_rs || i_jump_inm))
      else begin
         $error("o_nop high without a branch or jump flag");
         fail_count++;
      end

   jump_kinds_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_jump_rs && i_jump_inm))
      else begin
         $error("o_jump_rs and o_jump_inm high together");
         fail_count++;
      end

   mem_rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_mem_ctrl.rd_en && i_mem_ctrl.wr_en))
      else begin
         $error("memory read and write enabled together");
         fail_count++;
      end

   // First edge after reset still sees the cleared frames
   zero_after_reset: assert property (@(posedge i_clk)
      $fell(i_rst) |-> (i_ex_ctrl == '0 && i_mem_ctrl == '0 && i_wb_ctrl == '0 &&
                        i_pc == '0 && !i_branch && !i_jump_rs && !i_jump_inm && !i_nop))
      else begin
         $error("control outputs not zero in the cycle after reset");
         fail_count++;
      end

endmodule

bind instruction_decode tb_instruction_decode_assert u_assert (
   .i_clk      (i_clk),
   .i_rst      (i_rst),
   .i_ex_ctrl  (o_ex_ctrl),
   .i_mem_ctrl (o_mem_ctrl),
   .i_wb_ctrl  (o_wb_ctrl),
   .i_pc       (o_pc),
   .i_branch   (o_branch),
   .i_jump_rs  (o_jump_rs),
   .i_jump_inm (o_jump_inm),
   .i_nop      (o_nop)
);

//--- tb_instruction_decode.sv
`timescale 1ns/10ps

module tb_instruction_decode;

   import decode_pkg::*;

   localparam int CLK_PERIOD = 8;

   logic      i_clk;
   logic      i_rst;
   word_t     i_instruction;
   word_t     i_pc;
   logic      i_regfile_we;
   reg_addr_t i_regfile_addr;
   word_t     i_regfile_data;
   word_t     o_a;
   word_t     o_b;
   ex_ctrl_t  o_ex_ctrl;
   mem_ctrl_t o_mem_ctrl;
   wb_ctrl_t  o_wb_ctrl;
   imm_t      o_imm;
   shamt_t    o_shamt;
   word_t     o_pc;
   logic      o_branch;
   logic      o_jump_rs;
   logic      o_jump_inm;
   jump_imm_t o_jump_imm_addr;
   logic      o_nop;

   // Register contents as the testbench expects them
   word_t  reg_copy [NUM_REGS];
   integer seed;
   logic   table_built;

   // Stimulus table
   // Expected flags packed as {branch, jump_rs, jump_inm, nop}
   string      names[$];
   word_t      instrs[$];
   word_t      pcs[$];
   ex_ctrl_t   exp_ex[$];
   mem_ctrl_t  exp_mem[$];
   wb_ctrl_t   exp_wb[$];
   logic [3:0] exp_flags[$];

   instruction_decode dut0 (.*);

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   ////////////////////////////////////////////////////////////
   // Encoders and frame builders
   ////////////////////////////////////////////////////////////

   function automatic word_t encode_i(int op, int rs, int rt, int imm);
      return {opcode_t'(op), reg_addr_t'(rs), reg_addr_t'(rt), imm_t'(imm)};
   endfunction

   function automatic word_t encode_r(int rs, int rt, int rd, int shamt, int fn);
      return {OP_RTYPE, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd),
              shamt_t'(shamt), funct_t'(fn)};
   endfunction

   function automatic word_t encode_j(int op, int target);
      return {opcode_t'(op), jump_imm_t'(target)};
   endfunction

   function automatic ex_ctrl_t make_ex(int alu, int use_imm, int imm_uns, int use_shamt);
      ex_ctrl_t e;
      e.alu_op       = alu_op_t'(alu);
      e.use_imm      = (use_imm != 0);
      e.imm_unsigned = (imm_uns != 0);
      e.use_shamt    = (use_shamt != 0);
      return e;
   endfunction

   function automatic mem_ctrl_t make_mem(int rd_en, int wr_en, int uns, int size);
      mem_ctrl_t m;
      m.rd_en         = (rd_en != 0);
      m.wr_en         = (wr_en != 0);
      m.load_unsigned = (uns != 0);
      m.dsize         = dsize_t'(size);
      return m;
   endfunction

   function automatic wb_ctrl_t make_wb(int dest, int we, int from_alu, int link);
      wb_ctrl_t w;
      w.dest     = reg_addr_t'(dest);
      w.reg_we   = (we != 0);
      w.from_alu = (from_alu != 0);
      w.link_pc  = (link != 0);
      return w;
   endfunction

   task automatic add_entry(string name, word_t instr, ex_ctrl_t ex, mem_ctrl_t mem,
                            wb_ctrl_t wb, logic [3:0] flags);
      pcs.push_back(32'h0040_0000 + 32'(4 * names.size()));
      names.push_back(name);
      instrs.push_back(instr);
      exp_ex.push_back(ex);
      exp_mem.push_back(mem);
      exp_wb.push_back(wb);
      exp_flags.push_back(flags);
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic stop_on_error();
      $display("Simulation failed");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic check_word(string name, word_t exp, word_t act);
      if (act !== exp) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_ex(string name, ex_ctrl_t exp, ex_ctrl_t act);
      if (act !== exp) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_mem(string name, mem_ctrl_t exp, mem_ctrl_t act);
      if (act !== exp) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_wb(string name, wb_ctrl_t exp, wb_ctrl_t act);
      if (act !== exp) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("Mismatch %s: expected %b, actual %b", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_all_zero(string name);
      check_ex({name, " o_ex_ctrl"}, '0, o_ex_ctrl);
      check_mem({name, " o_mem_ctrl"}, '0, o_mem_ctrl);
      check_wb({name, " o_wb_ctrl"}, '0, o_wb_ctrl);
      check_word({name, " o_pc"}, '0, o_pc);
      check_bit({name, " o_branch"}, 1'b0, o_branch);
      check_bit({name, " o_jump_rs"}, 1'b0, o_jump_rs);
      check_bit({name, " o_jump_inm"}, 1'b0, o_jump_inm);
      check_bit({name, " o_nop"}, 1'b0, o_nop);
   endtask

   task automatic build_table();
      // Loads and stores
      add_entry("lb", encode_i(OP_LB, 1, 2, 16'h0004), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(1, 0, 0, DSIZE_BYTE), make_wb(2, 1, 0, 0), 4'b0000);
      add_entry("lh", encode_i(OP_LH, 3, 4, 16'hFFFE), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(1, 0, 0, DSIZE_HALF), make_wb(4, 1, 0, 0), 4'b0000);
      add_entry("lw", encode_i(OP_LW, 5, 6, 16'h0100), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(1, 0, 0, DSIZE_WORD), make_wb(6, 1, 0, 0), 4'b0000);
      add_entry("lbu", encode_i(OP_LBU, 7, 8, 16'h8004), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(1, 0, 1, DSIZE_BYTE), make_wb(8, 1, 0, 0), 4'b0000);
      add_entry("lhu", encode_i(OP_LHU, 9, 10, 16'h0022), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(1, 0, 1, DSIZE_HALF), make_wb(10, 1, 0, 0), 4'b0000);
      add_entry("lwu", encode_i(OP_LWU, 11, 12, 16'h7FFC), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(1, 0, 1, DSIZE_WORD), make_wb(12, 1, 0, 0), 4'b0000);
      add_entry("sb", encode_i(OP_SB, 13, 14, 16'h0001), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(0, 1, 0, DSIZE_BYTE), make_wb(14, 0, 0, 0), 4'b0000);
      add_entry("sh", encode_i(OP_SH, 15, 16, 16'h0002), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(0, 1, 0, DSIZE_HALF), make_wb(16, 0, 0, 0), 4'b0000);
      add_entry("sw", encode_i(OP_SW, 17, 18, 16'hFFF0), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(0, 1, 0, DSIZE_WORD), make_wb(18, 0, 0, 0), 4'b0000);
      // Immediate ALU
      add_entry("addi", encode_i(OP_ADDI, 19, 20, 16'h1234), make_ex(ALU_ADD, 1, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(20, 1, 1, 0), 4'b0000);
      add_entry("andi", encode_i(OP_ANDI, 21, 22, 16'hF0F0), make_ex(ALU_AND, 1, 1, 0),
                make_mem(0, 0, 0, 0), make_wb(22, 1, 1, 0), 4'b0000);
      add_entry("ori", encode_i(OP_ORI, 23, 24, 16'h00FF), make_ex(ALU_OR, 1, 1, 0),
                make_mem(0, 0, 0, 0), make_wb(24, 1, 1, 0), 4'b0000);
      add_entry("xori", encode_i(OP_XORI, 25, 26, 16'h5A5A), make_ex(ALU_XOR, 1, 1, 0),
                make_mem(0, 0, 0, 0), make_wb(26, 1, 1, 0), 4'b0000);
      add_entry("lui", encode_i(OP_LUI, 0, 27, 16'hABCD), make_ex(ALU_LUI, 1, 1, 0),
                make_mem(0, 0, 0, 0), make_wb(27, 1, 1, 0), 4'b0000);
      add_entry("slti", encode_i(OP_SLTI, 28, 29, 16'h8000), make_ex(ALU_SLT, 1, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(29, 1, 1, 0), 4'b0000);
      // R-type
      add_entry("sll", encode_r(0, 1, 2, 5, FN_SLL), make_ex(ALU_SLL, 0, 0, 1),
                make_mem(0, 0, 0, 0), make_wb(2, 1, 1, 0), 4'b0000);
      add_entry("srl", encode_r(0, 3, 4, 17, FN_SRL), make_ex(ALU_SRL, 0, 0, 1),
                make_mem(0, 0, 0, 0), make_wb(4, 1, 1, 0), 4'b0000);
      add_entry("sra", encode_r(0, 5, 6, 31, FN_SRA), make_ex(ALU_SRA, 0, 0, 1),
                make_mem(0, 0, 0, 0), make_wb(6, 1, 1, 0), 4'b0000);
      add_entry("sllv", encode_r(7, 8, 9, 0, FN_SLLV), make_ex(ALU_SLL, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(9, 1, 1, 0), 4'b0000);
      add_entry("srlv", encode_r(10, 11, 12, 0, FN_SRLV), make_ex(ALU_SRL, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(12, 1, 1, 0), 4'b0000);
      add_entry("srav", encode_r(13, 14, 15, 0, FN_SRAV), make_ex(ALU_SRA, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(15, 1, 1, 0), 4'b0000);
      add_entry("addu", encode_r(16, 17, 18, 0, FN_ADDU), make_ex(ALU_ADD, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(18, 1, 1, 0), 4'b0000);
      add_entry("subu", encode_r(19, 20, 21, 0, FN_SUBU), make_ex(ALU_SUB, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(21, 1, 1, 0), 4'b0000);
      add_entry("and", encode_r(22, 23, 24, 0, FN_AND), make_ex(ALU_AND, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(24, 1, 1, 0), 4'b0000);
      add_entry("or", encode_r(25, 26, 27, 0, FN_OR), make_ex(ALU_OR, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(27, 1, 1, 0), 4'b0000);
      add_entry("xor", encode_r(28, 29, 30, 0, FN_XOR), make_ex(ALU_XOR, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(30, 1, 1, 0), 4'b0000);
      add_entry("nor", encode_r(31, 1, 3, 0, FN_NOR), make_ex(ALU_NOR, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(3, 1, 1, 0), 4'b0000);
      add_entry("slt", encode_r(2, 4, 5, 0, FN_SLT), make_ex(ALU_SLT, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(5, 1, 1, 0), 4'b0000);
      add_entry("jr", encode_r(31, 0, 0, 0, FN_JR), make_ex(0, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(0, 1, 1, 0), 4'b0101);
      add_entry("jalr", encode_r(6, 0, 31, 0, FN_JALR), make_ex(0, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(31, 1, 1, 1), 4'b0101);
      // Branches resolved against the register copy
      add_entry("beq_same", encode_i(OP_BEQ, 3, 3, 16'h0010), make_ex(0, 1, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(3, 0, 0, 0),
                {1'b1, 2'b00, reg_copy[3] == reg_copy[3]});
      add_entry("beq_diff", encode_i(OP_BEQ, 4, 9, 16'hFFF8), make_ex(0, 1, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(9, 0, 0, 0),
                {1'b1, 2'b00, reg_copy[4] == reg_copy[9]});
      add_entry("bne_same", encode_i(OP_BNE, 0, 0, 16'h0020), make_ex(0, 1, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(0, 0, 0, 0),
                {1'b1, 2'b00, reg_copy[0] != reg_copy[0]});
      add_entry("bne_diff", encode_i(OP_BNE, 12, 20, 16'h0004), make_ex(0, 1, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(20, 0, 0, 0),
                {1'b1, 2'b00, reg_copy[12] != reg_copy[20]});
      // Jumps with a zero rd field in the target
      add_entry("j", encode_j(OP_J, 26'h2A007FF), make_ex(0, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(0, 0, 0, 0), 4'b0011);
      add_entry("jal", encode_j(OP_JAL, 26'h15207C0), make_ex(0, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(31, 1, 0, 1), 4'b0011);
      add_entry("bad_op", encode_i(6'h3F, 4, 5, 16'h07FF), make_ex(0, 0, 0, 0),
                make_mem(0, 0, 0, 0), make_wb(0, 0, 0, 0), 4'b0000);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      reg_addr_t rs_idx;
      reg_addr_t rt_idx;
      i_clk          = 1'b0;
      i_rst          = 1'b1;
      i_instruction  = encode_j(OP_JAL, 26'h0ABCDEF);
      i_pc           = 32'hDEAD_BEE0;
      i_regfile_we   = 1'b0;
      i_regfile_addr = '0;
      i_regfile_data = '0;
      table_built    = 1'b0;
      seed           = 55;

      reg_copy[0] = '0;
      for (int r = 1; r < NUM_REGS; r++) begin
         reg_copy[r] = $random(seed);
      end
      build_table();
      table_built = 1'b1;

      // Reset dominates a JAL on the input
      repeat (2) begin
         @(negedge i_clk);
         check_all_zero("in reset");
      end
      @(negedge i_clk);
      check_all_zero("in reset");
      i_rst         = 1'b0;
      i_instruction = '0;
      i_pc          = '0;
      #1;
      check_all_zero("after reset");

      // Fill the register file
      // New value visible only after the edge
      for (int r = 1; r < NUM_REGS; r++) begin
         @(negedge i_clk);
         i_regfile_we   = 1'b1;
         i_regfile_addr = reg_addr_t'(r);
         i_regfile_data = reg_copy[r];
         i_instruction  = encode_r(r, r, 0, 0, FN_ADDU);
         #1;
         check_word($sformatf("regfile r%0d before edge", r), '0, o_a);
         @(posedge i_clk);
         #1;
         check_word($sformatf("regfile r%0d after edge", r), reg_copy[r], o_a);
      end

      @(negedge i_clk);
      i_regfile_we = 1'b0;
      for (int i = 0; i < names.size(); i++) begin
         i_instruction = instrs[i];
         i_pc          = pcs[i];
         rs_idx        = instrs[i][RS_MSB -: REG_ADDR_W];
         rt_idx        = instrs[i][RT_MSB -: REG_ADDR_W];
         #1;
         check_word({names[i], " o_a"}, reg_copy[rs_idx], o_a);
         check_word({names[i], " o_b"}, reg_copy[rt_idx], o_b);
         @(negedge i_clk);
         check_ex({names[i], " o_ex_ctrl"}, exp_ex[i], o_ex_ctrl);
         check_mem({names[i], " o_mem_ctrl"}, exp_mem[i], o_mem_ctrl);
         check_wb({names[i], " o_wb_ctrl"}, exp_wb[i], o_wb_ctrl);
         check_word({names[i], " o_pc"}, pcs[i], o_pc);
         check_word({names[i], " o_imm"}, {16'h0, instrs[i][15:0]}, {16'h0, o_imm});
         check_word({names[i], " o_shamt"}, {27'h0, instrs[i][10:6]}, {27'h0, o_shamt});
         check_word({names[i], " o_jump_imm_addr"}, {6'h0, instrs[i][25:0]},
                    {6'h0, o_jump_imm_addr});
         check_bit({names[i], " o_branch"}, exp_flags[i][3], o_branch);
         check_bit({names[i], " o_jump_rs"}, exp_flags[i][2], o_jump_rs);
         check_bit({names[i], " o_jump_inm"}, exp_flags[i][1], o_jump_inm);
         check_bit({names[i], " o_nop"}, exp_flags[i][0], o_nop);
      end

      if (dut0.u_assert.fail_count == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("Simulation failed");
         $fatal(1, "Assertion failures: %0d", dut0.u_assert.fail_count);
      end
   end

   // Watchdog
   initial begin
      wait (table_built);
      #((names.size() + 40) * CLK_PERIOD * 4);
      $display("Timeout: the test did not reach its end in time");
      $display("Simulation failed");
      $fatal(1, "Watchdog expired");
   end

endmodule

//--- instruction_decode.f
decode_pkg.sv
id_regfile.sv
id_func_decoder.sv
id_main_decoder.sv
id_branch_unit.sv
id_stage_regs.sv
instruction_decode.sv
tb_instruction_decode_assert.sv
tb_instruction_decode.sv

//--- Makefile
# Verilator build and run for the instruction decode testbench

VERILATOR ?= verilator
TOP       ?= tb_instruction_decode
FILELIST  ?= instruction_decode.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BINARY) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
